// ==== logic/issue_settings.svh ====
// Sizes of the decode and issue stage. Four units and 32 architectural
// registers are assumed by the decoder and the unit enum in the package.
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Unit and register counts
//////////////////////////////////////////////////////////////////////

// ALU, branch, load/store and multiply
`define ISSUE_NUM_UNITS 4

// RV32I architectural registers, x0 included
`define ISSUE_NUM_REGS 32

// Instruction tag carried from fetch to exception reporting
`define ISSUE_ID_WIDTH 3

`endif

// ==== logic/issue_pkg.sv ====
// Types shared by the decode and issue stage. Opcode values are the
// RV32 encodings of instruction bits 6:2.
`default_nettype none

`include "issue_settings.svh"

package issue_pkg;

    typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0] reg_addr_t;

    ////////////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100,
        OTHER     = 5'b11111
    } opcode_e;

    // Values index the unit vectors
    typedef enum logic [$clog2(`ISSUE_NUM_UNITS)-1:0] {
        UNIT_ALU = 0,
        UNIT_BR  = 1,
        UNIT_LS  = 2,
        UNIT_MUL = 3
    } unit_id_e;

    typedef enum logic [1:0] {
        USER       = 2'b00,
        SUPERVISOR = 2'b01,
        MACHINE    = 2'b11
    } privilege_e;

    // Standard mcause values
    typedef enum logic [4:0] {
        INST_FAULT   = 5'd1,
        ILLEGAL_INST = 5'd2,
        BREAK        = 5'd3,
        ECALL_U      = 5'd8,
        ECALL_S      = 5'd9,
        ECALL_M      = 5'd11
    } exception_code_e;

    ////////////////////////////////////////////////////////////////////
    // Packets
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic [`ISSUE_ID_WIDTH-1:0] id;
        logic fetch_ok;
    } decode_packet_t;

    typedef struct packed {
        logic [`ISSUE_NUM_UNITS-1:0] unit_needed;
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        logic is_multicycle;
        logic is_ecall;
        logic is_ebreak;
        logic is_illegal;
    } decode_info_t;

    typedef struct packed {
        logic stage_valid;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic [`ISSUE_ID_WIDTH-1:0] id;
        opcode_e opcode;
        logic [2:0] fn3;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        logic uses_rd;
        logic is_multicycle;
    } issue_packet_t;

    typedef struct packed {
        logic valid;
        reg_addr_t rd_addr;
    } writeback_packet_t;

    typedef struct packed {
        logic valid;
        exception_code_e code;
        logic [31:0] tval;
        logic [`ISSUE_ID_WIDTH-1:0] id;
    } exception_packet_t;

    typedef struct packed {
        logic hold;
        logic flush;
    } issue_status_t;

    // Unknown opcode bits collapse to OTHER
    function automatic opcode_e to_opcode(input logic [4:0] bits);
        case (bits)
            LOAD, ARITH_IMM, AUIPC, STORE, ARITH, LUI,
            BRANCH, JALR, JAL, SYSTEM: return opcode_e'(bits);
            default: return OTHER;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== logic/instruction_decoder.sv ====
// RV32I/M only. Compressed encodings and FENCE/CSR forms have no unit
// here and are reported as illegal.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module instruction_decoder (
    input  wire logic [31:0]           instruction,
    output issue_pkg::decode_info_t    info
);
    import issue_pkg::*;

    localparam logic [31:0] ECALL_ENC  = 32'h0000_0073;
    localparam logic [31:0] EBREAK_ENC = 32'h0010_0073;

    opcode_e opc;
    logic [6:0] fn7;
    logic [`ISSUE_NUM_UNITS-1:0] unit_needed;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic full_width;

    assign opc = to_opcode(instruction[6:2]);
    assign fn7 = instruction[31:25];

    // Bits 1:0 must be 11 for a 32-bit instruction
    assign full_width = (instruction[1:0] == 2'b11);

    //////////////////////////////////////////////////////////////////////
    // Unit selection and register use per format
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        unit_needed = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        uses_rd = 1'b0;
        if (full_width) begin
            case (opc)
                LUI, AUIPC: begin
                    unit_needed[UNIT_ALU] = 1'b1;
                    uses_rd = 1'b1;
                end
                ARITH_IMM: begin
                    unit_needed[UNIT_ALU] = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rd = 1'b1;
                end
                ARITH: begin
                    // funct7 of 1 selects the M extension
                    if (fn7 == 7'b000_0001)
                        unit_needed[UNIT_MUL] = 1'b1;
                    else
                        unit_needed[UNIT_ALU] = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                    uses_rd = 1'b1;
                end
                JAL: begin
                    unit_needed[UNIT_BR] = 1'b1;
                    uses_rd = 1'b1;
                end
                JALR: begin
                    unit_needed[UNIT_BR] = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rd = 1'b1;
                end
                BRANCH: begin
                    unit_needed[UNIT_BR] = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
                LOAD: begin
                    unit_needed[UNIT_LS] = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rd = 1'b1;
                end
                STORE: begin
                    unit_needed[UNIT_LS] = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
                default: begin
                    unit_needed = '0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output packet
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        info.unit_needed = unit_needed;
        info.uses_rs1 = uses_rs1;
        info.uses_rs2 = uses_rs2;
        info.uses_rd = uses_rd;
        info.is_multicycle = unit_needed[UNIT_LS] | unit_needed[UNIT_MUL];
        info.is_ecall = (instruction == ECALL_ENC);
        info.is_ebreak = (instruction == EBREAK_ENC);
        // SYSTEM patterns other than the two exact encodings land here too
        info.is_illegal = ~|unit_needed & ~info.is_ecall & ~info.is_ebreak;
    end

endmodule

`default_nettype wire

// ==== logic/register_scoreboard.sv ====
// Tracks destinations of multicycle instructions by architectural address.
// A set and a write-back to the same register in one cycle leave it set.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module register_scoreboard (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                set_valid,
    input  wire issue_pkg::reg_addr_t          set_addr,
    input  wire issue_pkg::writeback_packet_t  wb,
    output logic [`ISSUE_NUM_REGS-1:0]         in_use
);
    import issue_pkg::*;

    logic [`ISSUE_NUM_REGS-1:0] in_use_next;

    // Write-back clears first so a new issue to the same rd wins
    always_comb begin
        in_use_next = in_use;
        if (wb.valid)
            in_use_next[wb.rd_addr] = 1'b0;
        if (set_valid)
            in_use_next[set_addr] = 1'b1;
        // x0 is hardwired to zero
        in_use_next[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            in_use <= '0;
        else
            in_use <= in_use_next;
    end

endmodule

`default_nettype wire

// ==== logic/issue_control.sv ====
// Single issue register with in-order issue to one unit at a time.
// An excepting instruction stays in the stage until status.flush.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module issue_control (
    input  wire                                clk,
    input  wire                                rst,
    input  wire issue_pkg::decode_packet_t     decode,
    input  wire issue_pkg::decode_info_t       info,
    input  wire [`ISSUE_NUM_REGS-1:0]          in_use,
    input  wire [`ISSUE_NUM_UNITS-1:0]         unit_ready,
    input  wire issue_pkg::issue_status_t      status,
    input  wire issue_pkg::privilege_e         current_privilege,
    input  wire                                exception_ack,
    output logic                               decode_advance,
    output issue_pkg::issue_packet_t           issue,
    output logic [`ISSUE_NUM_UNITS-1:0]        unit_new_request,
    output logic [31:0]                        constant_alu,
    output logic                               set_valid,
    output issue_pkg::reg_addr_t               set_addr,
    output issue_pkg::exception_packet_t       exception
);
    import issue_pkg::*;

    opcode_e decode_opc;
    logic [31:0] upper_imm;
    logic [31:0] const_base;
    logic [31:0] const_offset;

    logic issue_stage_ready;
    logic [`ISSUE_NUM_UNITS-1:0] unit_needed_r;
    logic [`ISSUE_NUM_UNITS-1:0] issue_ready;
    logic uses_rs1_r;
    logic uses_rs2_r;
    logic operand_conflict;
    logic issue_valid;
    logic instruction_issued;

    logic exception_pending;
    logic exception_reported;
    logic illegal_r;
    logic ecall_r;
    logic fetch_ok_r;
    logic new_exception;
    exception_code_e ecall_code;
    exception_code_e ecode;

    //////////////////////////////////////////////////////////////////////
    // Stage loading
    //////////////////////////////////////////////////////////////////////
    assign issue_stage_ready = (~issue.stage_valid | instruction_issued) & ~status.hold;
    assign decode_advance = decode.valid & issue_stage_ready;

    assign decode_opc = to_opcode(decode.instruction[6:2]);

    always_ff @(posedge clk) begin
        if (rst | status.flush)
            issue.stage_valid <= 1'b0;
        else if (issue_stage_ready)
            issue.stage_valid <= decode.valid;
    end

    always_ff @(posedge clk) begin
        if (issue_stage_ready) begin
            issue.pc <= decode.pc;
            issue.instruction <= decode.instruction;
            issue.id <= decode.id;
            issue.opcode <= decode_opc;
            issue.fn3 <= decode.instruction[14:12];
            issue.rs1_addr <= decode.instruction[19:15];
            issue.rs2_addr <= decode.instruction[24:20];
            issue.rd_addr <= decode.instruction[11:7];
            issue.uses_rd <= info.uses_rd;
            issue.is_multicycle <= info.is_multicycle;
            unit_needed_r <= info.unit_needed;
            uses_rs1_r <= info.uses_rs1;
            uses_rs2_r <= info.uses_rs2;
            illegal_r <= info.is_illegal;
            ecall_r <= info.is_ecall;
            fetch_ok_r <= decode.fetch_ok;
        end
    end

    // LUI, AUIPC, JAL and JALR results, pc + 4 doubles as link address
    assign upper_imm = {decode.instruction[31:12], 12'b0};
    assign const_base = (decode_opc == LUI) ? 32'd0 : decode.pc;
    assign const_offset = (decode_opc inside {LUI, AUIPC}) ? upper_imm : 32'd4;

    always_ff @(posedge clk) begin
        if (issue_stage_ready)
            constant_alu <= const_base + const_offset;
    end

    //////////////////////////////////////////////////////////////////////
    // Hazards and unit requests
    //////////////////////////////////////////////////////////////////////

    // rd check keeps write-after-write order with multicycle units
    assign operand_conflict = (uses_rs1_r & in_use[issue.rs1_addr])
                            | (uses_rs2_r & in_use[issue.rs2_addr])
                            | (issue.uses_rd & in_use[issue.rd_addr]);

    assign issue_valid = issue.stage_valid & ~operand_conflict & ~exception_pending
                       & ~status.hold & ~status.flush;
    assign issue_ready = unit_needed_r & unit_ready;
    assign unit_new_request = {`ISSUE_NUM_UNITS{issue_valid}} & issue_ready;
    assign instruction_issued = issue_valid & |issue_ready;

    // Only multicycle results are tracked
    assign set_valid = instruction_issued & issue.uses_rd & |issue.rd_addr
                     & issue.is_multicycle;
    assign set_addr = issue.rd_addr;

    //////////////////////////////////////////////////////////////////////
    // Pre-issue exceptions
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)
            exception_pending <= 1'b0;
        else if (issue_stage_ready)
            exception_pending <= info.is_illegal | ~decode.fetch_ok
                               | info.is_ecall | info.is_ebreak;
    end

    always_comb begin
        case (current_privilege)
            USER:       ecall_code = ECALL_U;
            SUPERVISOR: ecall_code = ECALL_S;
            MACHINE:    ecall_code = ECALL_M;
            default:    ecall_code = ECALL_U;
        endcase
    end

    assign ecode = illegal_r   ? ILLEGAL_INST :
                   ecall_r     ? ecall_code :
                   ~fetch_ok_r ? INST_FAULT :
                   BREAK;

    // Report once per instruction while it waits for the flush
    assign new_exception = issue.stage_valid & exception_pending & ~exception_reported
                         & ~status.hold & ~status.flush;

    always_ff @(posedge clk) begin
        if (rst | status.flush)
            exception_reported <= 1'b0;
        else if (new_exception)
            exception_reported <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            exception.valid <= 1'b0;
        else
            exception.valid <= (exception.valid | new_exception) & ~exception_ack;
    end

    always_ff @(posedge clk) begin
        if (new_exception) begin
            exception.code <= ecode;
            exception.tval <= issue.instruction;
            exception.id <= issue.id;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decode_issue_top.sv ====
// Decode and issue stage without register file or execution units.
// wb must only name registers that were issued to a multicycle unit.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module decode_issue_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire issue_pkg::decode_packet_t     decode,
    input  wire [`ISSUE_NUM_UNITS-1:0]         unit_ready,
    input  wire issue_pkg::writeback_packet_t  wb,
    input  wire issue_pkg::issue_status_t      status,
    input  wire issue_pkg::privilege_e         current_privilege,
    input  wire                                exception_ack,
    output logic                               decode_advance,
    output issue_pkg::issue_packet_t           issue,
    output logic [`ISSUE_NUM_UNITS-1:0]        unit_new_request,
    output logic [31:0]                        constant_alu,
    output issue_pkg::exception_packet_t       exception
);
    import issue_pkg::*;

    decode_info_t info;
    logic [`ISSUE_NUM_REGS-1:0] in_use;
    logic set_valid;
    reg_addr_t set_addr;

    instruction_decoder u_decoder (
        .instruction (decode.instruction),
        .info        (info)
    );

    register_scoreboard u_scoreboard (
        .clk       (clk),
        .rst       (rst),
        .set_valid (set_valid),
        .set_addr  (set_addr),
        .wb        (wb),
        .in_use    (in_use)
    );

    issue_control u_control (
        .clk               (clk),
        .rst               (rst),
        .decode            (decode),
        .info              (info),
        .in_use            (in_use),
        .unit_ready        (unit_ready),
        .status            (status),
        .current_privilege (current_privilege),
        .exception_ack     (exception_ack),
        .decode_advance    (decode_advance),
        .issue             (issue),
        .unit_new_request  (unit_new_request),
        .constant_alu      (constant_alu),
        .set_valid         (set_valid),
        .set_addr          (set_addr),
        .exception         (exception)
    );

endmodule

`default_nettype wire

// ==== bench/decode_issue_tb.sv ====
// Table-driven testbench for the decode and issue stage. Units, write-back,
// status and exception acknowledge are modelled here in place of the pipeline.
`timescale 1ns/1ps
`default_nettype none

`include "issue_settings.svh"

module decode_issue_tb;
    import issue_pkg::*;

    typedef enum logic [1:0] {NO_STALL, READY_LOW, HOLD_HIGH} stall_e;

    // One stimulus row with its expected response
    typedef struct packed {
        logic [31:0] instruction;
        logic [31:0] pc;
        logic [`ISSUE_ID_WIDTH-1:0] id;
        logic fetch_ok;
        privilege_e priv;
        stall_e stall;
        logic [3:0] stall_len;
        logic withhold_wb;
        unit_id_e exp_unit;
        logic [31:0] exp_const;
        logic exp_exc;
        exception_code_e exp_code;
    } row_t;

    logic clk;
    logic rst;
    decode_packet_t decode;
    logic [`ISSUE_NUM_UNITS-1:0] unit_ready;
    writeback_packet_t wb;
    issue_status_t status;
    privilege_e current_privilege;
    logic exception_ack;
    logic decode_advance;
    issue_packet_t issue;
    logic [`ISSUE_NUM_UNITS-1:0] unit_new_request;
    logic [31:0] constant_alu;
    exception_packet_t exception;

    row_t rows[$];
    int cycle_count = 0;
    int cycle_limit = 0;
    int unit_errors = 0;
    int issue_errors = 0;
    int const_errors = 0;
    int exc_errors = 0;
    int flow_errors = 0;
    logic held_valid;
    reg_addr_t held_rd;

    decode_issue_top u_dut (
        .clk               (clk),
        .rst               (rst),
        .decode            (decode),
        .unit_ready        (unit_ready),
        .wb                (wb),
        .status            (status),
        .current_privilege (current_privilege),
        .exception_ack     (exception_ack),
        .decode_advance    (decode_advance),
        .issue             (issue),
        .unit_new_request  (unit_new_request),
        .constant_alu      (constant_alu),
        .exception         (exception)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Timeout and result reporting
    //////////////////////////////////////////////////////////////////////
    task automatic print_counts();
        $display("errors: unit %0d, issue %0d, constant %0d, exception %0d, flow %0d",
                 unit_errors, issue_errors, const_errors, exc_errors, flow_errors);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            print_counts();
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic compare_units(input logic [`ISSUE_NUM_UNITS-1:0] got,
                                 input logic [`ISSUE_NUM_UNITS-1:0] exp, input string what);
        if (got !== exp) begin
            unit_errors++;
            $display("error at %0t: %s unit request %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_issue(input issue_packet_t got, input issue_packet_t exp);
        if (got !== exp) begin
            issue_errors++;
            $display("error at %0t: issued %h pc %h id %0d rd x%0d, packet %h expected %h",
                     $time, got.instruction, got.pc, got.id, got.rd_addr, got, exp);
        end
    endtask

    task automatic compare_constant(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            const_errors++;
            $display("error at %0t: constant_alu %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_exception(input exception_packet_t got, input exception_packet_t exp);
        if (got !== exp) begin
            exc_errors++;
            $display("error at %0t: exception code %0d tval %h id %0d, expected %0d %h %0d",
                     $time, got.code, got.tval, got.id, exp.code, exp.tval, exp.id);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flow_errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Table building and row execution
    //////////////////////////////////////////////////////////////////////

    // pc and id follow the row position
    function automatic void add_row(input logic [31:0] instruction, input logic fetch_ok,
            input privilege_e priv, input stall_e stall, input logic [3:0] stall_len,
            input logic withhold_wb, input unit_id_e exp_unit, input logic [31:0] exp_const,
            input logic exp_exc, input exception_code_e exp_code);
        row_t r;
        int n;
        n = rows.size();
        r.instruction = instruction;
        r.pc = 32'h1000 + 4 * n;
        r.id = n[`ISSUE_ID_WIDTH-1:0];
        r.fetch_ok = fetch_ok;
        r.priv = priv;
        r.stall = stall;
        r.stall_len = stall_len;
        r.withhold_wb = withhold_wb;
        r.exp_unit = exp_unit;
        r.exp_const = exp_const;
        r.exp_exc = exp_exc;
        r.exp_code = exp_code;
        rows.push_back(r);
    endfunction

    task automatic run_row(input row_t r);
        logic [`ISSUE_NUM_UNITS-1:0] exp_units;
        issue_packet_t exp_issue;
        exception_packet_t exp_exception;
        int stall_cycles;
        int wb_delay;
        int waited;
        logic blocked;
        logic responded;
        logic needs_wb;
        logic hazard_row;

        exp_units = '0;
        if (!r.exp_exc)
            exp_units[r.exp_unit] = 1'b1;
        exp_issue = '0;
        exp_issue.stage_valid = 1'b1;
        exp_issue.pc = r.pc;
        exp_issue.instruction = r.instruction;
        exp_issue.id = r.id;
        exp_issue.opcode = opcode_e'(r.instruction[6:2]);
        exp_issue.fn3 = r.instruction[14:12];
        exp_issue.rs1_addr = r.instruction[19:15];
        exp_issue.rs2_addr = r.instruction[24:20];
        exp_issue.rd_addr = r.instruction[11:7];
        // rd is written by every format except branch, store and system
        exp_issue.uses_rd = !(r.instruction[6:2] inside {BRANCH, STORE, SYSTEM});
        exp_issue.is_multicycle = r.exp_unit inside {UNIT_LS, UNIT_MUL};
        exp_exception.valid = 1'b1;
        exp_exception.code = r.exp_code;
        exp_exception.tval = r.instruction;
        exp_exception.id = r.id;
        stall_cycles = r.stall_len;
        if (r.stall == READY_LOW)
            stall_cycles += $urandom % 3;
        wb_delay = 1 + $urandom % 4;

        // Stage is empty here, so the packet loads on the next edge
        @(negedge clk);
        decode.valid = 1'b1;
        decode.pc = r.pc;
        decode.instruction = r.instruction;
        decode.id = r.id;
        decode.fetch_ok = r.fetch_ok;
        current_privilege = r.priv;
        if (r.stall == READY_LOW)
            unit_ready = ~exp_units;
        #1;
        compare_flag(decode_advance, 1'b1, "decode_advance with empty stage");

        // Next packet stays offered while the stage is stalled
        repeat (stall_cycles) begin
            @(negedge clk);
            status.hold = (r.stall == HOLD_HIGH);
            #1;
            compare_units(unit_new_request, '0, "stalled");
            compare_flag(decode_advance, 1'b0, "decode_advance while stalled");
        end

        // Wait for a request or an exception, releasing a withheld write-back
        hazard_row = held_valid;
        responded = 1'b0;
        waited = 0;
        while (!responded) begin
            @(negedge clk);
            decode.valid = 1'b0;
            unit_ready = '1;
            status.hold = 1'b0;
            wb.valid = 1'b0;
            blocked = held_valid;
            if (held_valid && waited == wb_delay) begin
                wb.valid = 1'b1;
                wb.rd_addr = held_rd;
                held_valid = 1'b0;
            end
            #1;
            if (blocked)
                compare_units(unit_new_request, '0, "hazard");
            else
                responded = |unit_new_request | exception.valid;
            waited++;
        end

        // Request right after the stage loads, exception.valid one cycle later
        if (!hazard_row)
            compare_flag(waited == (r.exp_exc ? 2 : 1), 1'b1, "response in expected cycle");

        if (r.exp_exc) begin
            compare_units(unit_new_request, '0, "excepting");
            compare_exception(exception, exp_exception);
            repeat (1 + $urandom % 3) begin
                @(negedge clk);
                #1;
                compare_flag(exception.valid, 1'b1, "exception.valid before ack");
                compare_units(unit_new_request, '0, "excepting");
            end
            @(negedge clk);
            exception_ack = 1'b1;
            @(negedge clk);
            exception_ack = 1'b0;
            status.flush = 1'b1;
            #1;
            compare_flag(exception.valid, 1'b0, "exception.valid after ack");
            @(negedge clk);
            status.flush = 1'b0;
            #1;
            compare_flag(issue.stage_valid, 1'b0, "stage valid after flush");
        end else begin
            compare_units(unit_new_request, exp_units, "issue");
            compare_issue(issue, exp_issue);
            compare_constant(constant_alu, r.exp_const);
            needs_wb = (r.exp_unit inside {UNIT_LS, UNIT_MUL}) && r.instruction[6:2] != STORE
                       && r.instruction[11:7] != 5'd0;
            @(negedge clk);
            if (needs_wb && r.withhold_wb) begin
                held_valid = 1'b1;
                held_rd = r.instruction[11:7];
            end else if (needs_wb) begin
                wb.valid = 1'b1;
                wb.rd_addr = r.instruction[11:7];
            end
            #1;
            compare_units(unit_new_request, '0, "after issue");
            @(negedge clk);
            wb.valid = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h5363abc8));
        rst = 1'b1;
        decode = '0;
        unit_ready = '1;
        wb = '0;
        status = '0;
        current_privilege = MACHINE;
        exception_ack = 1'b0;
        held_valid = 1'b0;
        held_rd = '0;

        // Routing and constants, pc starts at 0x1000
        add_row(32'h123450B7, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h1234_5000, 0, BREAK);
        add_row(32'h00010117, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0001_1004, 0, BREAK);
        add_row(32'h008000EF, 1, MACHINE, NO_STALL, 0, 0, UNIT_BR, 32'h0000_100C, 0, BREAK);
        add_row(32'h000100E7, 1, MACHINE, NO_STALL, 0, 0, UNIT_BR, 32'h0000_1010, 0, BREAK);
        add_row(32'h00208463, 1, MACHINE, NO_STALL, 0, 0, UNIT_BR, 32'h0000_1014, 0, BREAK);
        add_row(32'h002081B3, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0000_1018, 0, BREAK);
        add_row(32'h00500213, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0000_101C, 0, BREAK);
        add_row(32'h022083B3, 1, MACHINE, NO_STALL, 0, 0, UNIT_MUL, 32'h0000_1020, 0, BREAK);
        // Back-pressure on store and multiply
        add_row(32'h00112223, 1, MACHINE, READY_LOW, 3, 0, UNIT_LS, 32'h0000_1024, 0, BREAK);
        add_row(32'h022083B3, 1, MACHINE, READY_LOW, 2, 0, UNIT_MUL, 32'h0000_1028, 0, BREAK);
        // lw x5 then add reading x5, then lw x5 twice for the WAW case
        add_row(32'h00012283, 1, MACHINE, NO_STALL, 0, 1, UNIT_LS, 32'h0000_102C, 0, BREAK);
        add_row(32'h00128333, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0000_1030, 0, BREAK);
        add_row(32'h00012283, 1, MACHINE, NO_STALL, 0, 1, UNIT_LS, 32'h0000_1034, 0, BREAK);
        add_row(32'h0081A283, 1, MACHINE, NO_STALL, 0, 0, UNIT_LS, 32'h0000_1038, 0, BREAK);
        add_row(32'h00500213, 1, MACHINE, HOLD_HIGH, 4, 0, UNIT_ALU, 32'h0000_103C, 0, BREAK);
        // Pre-issue exceptions
        add_row(32'hFFFFFFFF, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0, 1, ILLEGAL_INST);
        add_row(32'h00000073, 1, USER, NO_STALL, 0, 0, UNIT_ALU, 32'h0, 1, ECALL_U);
        add_row(32'h00000073, 1, SUPERVISOR, NO_STALL, 0, 0, UNIT_ALU, 32'h0, 1, ECALL_S);
        add_row(32'h00000073, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0, 1, ECALL_M);
        add_row(32'h00100073, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0, 1, BREAK);
        add_row(32'h00500213, 0, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0, 1, INST_FAULT);
        add_row(32'hFFFFFFFF, 0, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0, 1, ILLEGAL_INST);
        add_row(32'h002081B3, 1, MACHINE, NO_STALL, 0, 0, UNIT_ALU, 32'h0000_105C, 0, BREAK);

        cycle_limit = 40 * rows.size() + 5;

        repeat (5) @(negedge clk);
        rst = 1'b0;

        foreach (rows[i])
            run_row(rows[i]);

        print_counts();
        if (unit_errors + issue_errors + const_errors + exc_errors + flow_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/issue_pkg.sv
logic/instruction_decoder.sv
logic/register_scoreboard.sv
logic/issue_control.sv
logic/decode_issue_top.sv
bench/decode_issue_tb.sv

// ==== Bender.yml ====
package:
  name: decode_issue

sources:
  - include_dirs:
      - logic
    files:
      - logic/issue_pkg.sv
      - logic/instruction_decoder.sv
      - logic/register_scoreboard.sv
      - logic/issue_control.sv
      - logic/decode_issue_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/decode_issue_tb.sv
